/* Makefile */
SIM      := verilator
TOP      := mem_top_tb
FILELIST := mem_top.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := PASS: all tests

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/mem_bus_port.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_bus_port
  (input  logic                                 clk_i
   , input  logic                               reset_i

   , input  mem_pkg::bus_req_s                  ptw_req_i
   , input  logic                               ptw_v_i
   , output logic                               ptw_done_o

   , input  mem_pkg::bus_req_s                  data_req_i
   , input  logic                               data_v_i
   , output logic                               data_done_o

   , output logic [mem_pkg::data_width_lp-1:0]  rdata_o

   , output logic                               wb_cyc_o
   , output logic                               wb_stb_o
   , output logic                               wb_we_o
   , output logic [mem_pkg::paddr_width_lp-1:0] wb_adr_o
   , output logic [mem_pkg::data_width_lp-1:0]  wb_dat_o
   , input  logic [mem_pkg::data_width_lp-1:0]  wb_dat_i
   , input  logic                               wb_ack_i
   );

  import mem_pkg::*;

  logic     cyc_r;
  logic     served_ptw_r;
  logic     launch;
  bus_req_s req_r;

  assign launch = !cyc_r && (ptw_v_i || data_v_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cyc_r       <= 1'b0;
      ptw_done_o  <= 1'b0;
      data_done_o <= 1'b0;
    end else begin
      ptw_done_o  <= 1'b0;
      data_done_o <= 1'b0;
      if (launch) begin
        cyc_r <= 1'b1;
      end else if (cyc_r && wb_ack_i) begin
        cyc_r       <= 1'b0;
        ptw_done_o  <= served_ptw_r;
        data_done_o <= !served_ptw_r;
      end
    end
  end

  // Walker wins if both ask at once
  always_ff @(posedge clk_i) begin
    if (launch) begin
      req_r        <= ptw_v_i ? ptw_req_i : data_req_i;
      served_ptw_r <= ptw_v_i;
    end
    if (cyc_r && wb_ack_i) begin
      rdata_o <= wb_dat_i;
    end
  end

  assign wb_cyc_o = cyc_r;
  assign wb_stb_o = cyc_r;
  assign wb_we_o  = req_r.we;
  assign wb_adr_o = req_r.adr;
  assign wb_dat_o = req_r.dat;

  assert property (@(posedge clk_i) disable iff (reset_i)
    wb_stb_o |-> wb_cyc_o)
    else $error("Wishbone: stb without cyc");

  // Classic cycle holds every master output until ack
  assert property (@(posedge clk_i) disable iff (reset_i)
    wb_cyc_o && !wb_ack_i |=> wb_cyc_o && $stable({wb_we_o, wb_adr_o, wb_dat_o}))
    else $error("Wishbone: master outputs changed before ack");

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // Address and data geometry
  localparam int vaddr_width_lp       = 32;
  localparam int paddr_width_lp       = 32;
  localparam int data_width_lp        = 32;
  localparam int page_offset_width_lp = 12;
  localparam int vpn_width_lp         = vaddr_width_lp - page_offset_width_lp;
  localparam int ppn_width_lp         = paddr_width_lp - page_offset_width_lp;

  // Two-level walk, 10 bits of VPN per level
  localparam int pt_idx_width_lp      = vpn_width_lp / 2;

  localparam int tlb_els_lp           = 4;
  localparam int tlb_idx_width_lp     = $clog2(tlb_els_lp);

  typedef enum logic {
    e_load  = 1'b0,
    e_store = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e                   op;
    logic [vaddr_width_lp-1:0] vaddr;
    logic [data_width_lp-1:0]  wdata;
  } mem_cmd_s;

  typedef struct packed {
    logic [data_width_lp-1:0] rdata;
    logic                     page_fault;
    // Command needed a page walk
    logic                     miss;
  } mem_resp_s;

  typedef struct packed {
    logic [ppn_width_lp-1:0]                    ppn;
    logic [data_width_lp-ppn_width_lp-4:0]      rsvd;
    logic                                       w;
    logic                                       r;
    logic                                       v;
  } pte_s;

  typedef struct packed {
    logic [ppn_width_lp-1:0] ppn;
    logic                    r;
    logic                    w;
  } tlb_entry_s;

  typedef struct packed {
    logic                    en;
    logic [ppn_width_lp-1:0] base_ppn;
  } xlate_ctl_s;

  typedef struct packed {
    logic                      we;
    logic [paddr_width_lp-1:0] adr;
    logic [data_width_lp-1:0]  dat;
  } bus_req_s;

endpackage

`default_nettype wire

/* logic/mem_ptw.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_ptw
  (input  logic                               clk_i
   , input  logic                             reset_i

   , input  logic                             start_i
   , input  logic [mem_pkg::vpn_width_lp-1:0] vpn_i
   , input  logic                             is_store_i
   , input  logic [mem_pkg::ppn_width_lp-1:0] base_ppn_i

   , output mem_pkg::bus_req_s                bus_req_o
   , output logic                             bus_v_o
   , input  logic                             bus_done_i
   , input  logic [mem_pkg::data_width_lp-1:0] bus_rdata_i

   , output logic                             done_o
   , output logic                             fault_o
   , output mem_pkg::tlb_entry_s              entry_o
   );

  import mem_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_req,
    e_wait
  } ptw_state_e;

  ptw_state_e                state_r;
  logic                      level2_r;
  logic                      is_store_r;
  logic [vpn_width_lp-1:0]   vpn_r;
  logic [paddr_width_lp-1:0] pte_addr_r;

  pte_s pte;
  logic leaf;
  logic perm_ok;
  logic descend;

  assign pte     = pte_s'(bus_rdata_i);
  assign leaf    = pte.r | pte.w;
  assign perm_ok = is_store_r ? pte.w : pte.r;
  // Pointers are only followed from level one
  assign descend = pte.v && !leaf && !level2_r;

  // One-cycle request pulse, the bus port latches it
  assign bus_v_o       = (state_r == e_req);
  assign bus_req_o.we  = 1'b0;
  assign bus_req_o.adr = pte_addr_r;
  assign bus_req_o.dat = '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_r)
        e_idle: begin
          if (start_i) begin
            state_r <= e_req;
          end
        end
        e_req: state_r <= e_wait;
        e_wait: begin
          if (bus_done_i) begin
            state_r <= descend ? e_req : e_idle;
            done_o  <= !descend;
          end
        end
        default: state_r <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == e_idle && start_i) begin
      level2_r   <= 1'b0;
      is_store_r <= is_store_i;
      vpn_r      <= vpn_i;
      pte_addr_r <= {base_ppn_i, vpn_i[vpn_width_lp-1 -: pt_idx_width_lp], 2'b00};
    end else if (state_r == e_wait && bus_done_i) begin
      if (descend) begin
        level2_r   <= 1'b1;
        pte_addr_r <= {pte.ppn, vpn_r[pt_idx_width_lp-1:0], 2'b00};
      end else begin
        fault_o <= !pte.v || !leaf || !perm_ok;
        // Level-one leaf maps a superpage
        entry_o.ppn <= level2_r ? pte.ppn
                                : {pte.ppn[ppn_width_lp-1:pt_idx_width_lp],
                                   vpn_r[pt_idx_width_lp-1:0]};
        entry_o.r   <= pte.r;
        entry_o.w   <= pte.w;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mem_tlb.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_tlb
  (input  logic                             clk_i
   , input  logic                           reset_i
   , input  logic                           flush_i

   , input  logic [mem_pkg::vpn_width_lp-1:0] lookup_vpn_i
   , output logic                           hit_o
   , output mem_pkg::tlb_entry_s            entry_o

   , input  logic                           fill_v_i
   , input  logic [mem_pkg::vpn_width_lp-1:0] fill_vpn_i
   , input  mem_pkg::tlb_entry_s            fill_entry_i
   );

  import mem_pkg::*;

  logic [tlb_els_lp-1:0]       valid_r;
  logic [vpn_width_lp-1:0]     tag_r   [tlb_els_lp];
  tlb_entry_s                  entry_r [tlb_els_lp];
  logic [tlb_idx_width_lp-1:0] rr_ptr_r;
  logic [tlb_els_lp-1:0]       hit_vec;

  // Parallel tag compare
  always_comb begin
    for (int i = 0; i < tlb_els_lp; i++) begin
      hit_vec[i] = valid_r[i] && (tag_r[i] == lookup_vpn_i);
    end
  end

  // At most one slot matches, so an OR of the masked entries selects it
  always_comb begin
    entry_o = '0;
    for (int i = 0; i < tlb_els_lp; i++) begin
      if (hit_vec[i]) begin
        entry_o = entry_o | entry_r[i];
      end
    end
  end

  assign hit_o = |hit_vec;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
    end else if (flush_i) begin
      valid_r  <= '0;
    end else if (fill_v_i) begin
      valid_r[rr_ptr_r] <= 1'b1;
      rr_ptr_r          <= rr_ptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[rr_ptr_r]   <= fill_vpn_i;
      entry_r[rr_ptr_r] <= fill_entry_i;
    end
  end

  // Refills only follow a miss, so no VPN is ever cached twice
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(hit_vec))
    else $error("TLB: more than one slot hit");

endmodule

`default_nettype wire

/* logic/mem_top.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_top
  (input  logic                                 clk_i
   , input  logic                               reset_i

   , input  mem_pkg::mem_cmd_s                  cmd_i
   , input  logic                               cmd_v_i
   , output logic                               cmd_ready_o

   , output mem_pkg::mem_resp_s                 resp_o
   , output logic                               resp_v_o
   , input  logic                               resp_ready_i

   , input  mem_pkg::xlate_ctl_s                xlate_i
   , input  logic                               tlb_fence_i

   , output logic                               wb_cyc_o
   , output logic                               wb_stb_o
   , output logic                               wb_we_o
   , output logic [mem_pkg::paddr_width_lp-1:0] wb_adr_o
   , output logic [mem_pkg::data_width_lp-1:0]  wb_dat_o
   , input  logic [mem_pkg::data_width_lp-1:0]  wb_dat_i
   , input  logic                               wb_ack_i
   );

  import mem_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_walk,
    e_access,
    e_respond
  } ctl_state_e;

  ctl_state_e                state_r, state_n;
  logic                      cmd_ready_r;
  logic                      data_v_r;
  mem_cmd_s                  cmd_r;
  mem_resp_s                 resp_r;
  logic [paddr_width_lp-1:0] paddr_r;

  logic                      accept;
  logic                      need_walk;
  logic                      hit_perm_ok;
  logic                      tlb_hit;
  tlb_entry_s                tlb_entry;

  bus_req_s                  ptw_bus_req;
  logic                      ptw_bus_v;
  logic                      ptw_bus_done;
  logic                      ptw_done;
  logic                      ptw_fault;
  tlb_entry_s                ptw_entry;

  bus_req_s                  data_req;
  logic                      data_done;
  logic [data_width_lp-1:0]  bus_rdata;

  assign accept      = cmd_v_i && cmd_ready_o;
  // Lookup runs on the incoming command so the decision is made at acceptance
  assign need_walk   = xlate_i.en && !tlb_hit;
  assign hit_perm_ok = (cmd_i.op == e_store) ? tlb_entry.w : tlb_entry.r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (accept) begin
          if (need_walk) begin
            state_n = e_walk;
          end else if (xlate_i.en && !hit_perm_ok) begin
            state_n = e_respond;
          end else begin
            state_n = e_access;
          end
        end
      end
      e_walk: begin
        if (ptw_done) begin
          state_n = ptw_fault ? e_respond : e_access;
        end
      end
      e_access: begin
        if (data_done) begin
          state_n = e_respond;
        end
      end
      e_respond: begin
        if (resp_ready_i) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= e_idle;
      cmd_ready_r <= 1'b0;
      data_v_r    <= 1'b0;
    end else begin
      state_r     <= state_n;
      cmd_ready_r <= (state_n == e_idle);
      // Data request pulses once on entry to access
      data_v_r    <= (state_n == e_access) && (state_r != e_access);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_r             <= cmd_i;
      resp_r.miss       <= need_walk;
      resp_r.page_fault <= xlate_i.en && tlb_hit && !hit_perm_ok;
      resp_r.rdata      <= '0;
      paddr_r           <= xlate_i.en
                           ? {tlb_entry.ppn, cmd_i.vaddr[page_offset_width_lp-1:0]}
                           : cmd_i.vaddr;
    end else if (state_r == e_walk && ptw_done) begin
      resp_r.page_fault <= ptw_fault;
      paddr_r           <= {ptw_entry.ppn, cmd_r.vaddr[page_offset_width_lp-1:0]};
    end else if (data_done && cmd_r.op == e_load) begin
      resp_r.rdata      <= bus_rdata;
    end
  end

  assign data_req.we  = (cmd_r.op == e_store);
  assign data_req.adr = paddr_r;
  assign data_req.dat = cmd_r.wdata;

  assign cmd_ready_o = cmd_ready_r;
  assign resp_v_o    = (state_r == e_respond);
  assign resp_o      = resp_r;

  mem_tlb dtlb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.flush_i(tlb_fence_i)
     ,.lookup_vpn_i(cmd_i.vaddr[vaddr_width_lp-1 -: vpn_width_lp])
     ,.hit_o(tlb_hit)
     ,.entry_o(tlb_entry)
     ,.fill_v_i(ptw_done && !ptw_fault)
     ,.fill_vpn_i(cmd_r.vaddr[vaddr_width_lp-1 -: vpn_width_lp])
     ,.fill_entry_i(ptw_entry)
     );

  mem_ptw ptw
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.start_i(accept && need_walk)
     ,.vpn_i(cmd_i.vaddr[vaddr_width_lp-1 -: vpn_width_lp])
     ,.is_store_i(cmd_i.op == e_store)
     ,.base_ppn_i(xlate_i.base_ppn)
     ,.bus_req_o(ptw_bus_req)
     ,.bus_v_o(ptw_bus_v)
     ,.bus_done_i(ptw_bus_done)
     ,.bus_rdata_i(bus_rdata)
     ,.done_o(ptw_done)
     ,.fault_o(ptw_fault)
     ,.entry_o(ptw_entry)
     );

  mem_bus_port bus_port
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.ptw_req_i(ptw_bus_req)
     ,.ptw_v_i(ptw_bus_v)
     ,.ptw_done_o(ptw_bus_done)
     ,.data_req_i(data_req)
     ,.data_v_i(data_v_r)
     ,.data_done_o(data_done)
     ,.rdata_o(bus_rdata)
     ,.wb_cyc_o(wb_cyc_o)
     ,.wb_stb_o(wb_stb_o)
     ,.wb_we_o(wb_we_o)
     ,.wb_adr_o(wb_adr_o)
     ,.wb_dat_o(wb_dat_o)
     ,.wb_dat_i(wb_dat_i)
     ,.wb_ack_i(wb_ack_i)
     );

  assert property (@(posedge clk_i) disable iff (reset_i)
    !(cmd_ready_o && resp_v_o))
    else $error("mem_top: ready and response valid together");

  // Response held under back-pressure
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o))
    else $error("mem_top: response dropped or changed while stalled");

endmodule

`default_nettype wire

/* mem_top.f */
logic/mem_pkg.sv
logic/mem_tlb.sv
logic/mem_ptw.sv
logic/mem_bus_port.sv
logic/mem_top.sv
test/wb_mem_model.sv
test/mem_top_tb.sv

/* test/mem_top_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module mem_top_tb;

  import mem_pkg::*;

  localparam int          clk_half_lp       = 20;
  localparam int          drive_delay_lp    = 2;
  localparam int          timeout_cycles_lp = 40 * 60;
  localparam logic [19:0] root_ppn_lp       = 20'd1;
  localparam logic [19:0] l2_ppn_lp         = 20'd2;

  logic        clk_i;
  logic        reset_i;
  mem_cmd_s    cmd_i;
  logic        cmd_v_i;
  logic        cmd_ready_o;
  mem_resp_s   resp_o;
  logic        resp_v_o;
  logic        resp_ready_i;
  xlate_ctl_s  xlate_i;
  logic        tlb_fence_i;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [31:0] wb_adr_o;
  logic [31:0] wb_dat_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;

  int          seed;
  int          errors     = 0;
  int          cycles     = 0;
  int          cmd_count  = 0;
  int          resp_count = 0;
  logic        stall_mode;
  logic        outstanding_r;
  mem_resp_s   exp_resp;
  int          exp_cycles;
  int          cyc_base;

  // Reference TLB state
  logic        ref_valid [tlb_els_lp];
  logic [19:0] ref_tag   [tlb_els_lp];
  tlb_entry_s  ref_entry [tlb_els_lp];
  int          ref_ptr;

  mem_top dut_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_i(resp_ready_i)
     ,.xlate_i(xlate_i)
     ,.tlb_fence_i(tlb_fence_i)
     ,.wb_cyc_o(wb_cyc_o)
     ,.wb_stb_o(wb_stb_o)
     ,.wb_we_o(wb_we_o)
     ,.wb_adr_o(wb_adr_o)
     ,.wb_dat_o(wb_dat_o)
     ,.wb_dat_i(wb_dat_i)
     ,.wb_ack_i(wb_ack_i)
     );

  wb_mem_model mem_model
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.wb_cyc_i(wb_cyc_o)
     ,.wb_stb_i(wb_stb_o)
     ,.wb_we_i(wb_we_o)
     ,.wb_adr_i(wb_adr_o)
     ,.wb_dat_i(wb_dat_o)
     ,.wb_dat_o(wb_dat_i)
     ,.wb_ack_o(wb_ack_i)
     );

  initial clk_i = 1'b0;
  always #clk_half_lp clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles_lp) begin
      $display("Timeout: simulation still running after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= 1'b0;
    end else if (cmd_v_i && cmd_ready_o) begin
      outstanding_r <= 1'b1;
    end else if (resp_v_o && resp_ready_i) begin
      outstanding_r <= 1'b0;
      resp_count    <= resp_count + 1;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && resp_ready_i |-> resp_o == exp_resp)
    else begin
      errors = errors + 1;
      $display("ERR %0t: response %h, expected %h", $time, $sampled(resp_o), exp_resp);
    end

  // Wishbone cycles spent on one command
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && resp_ready_i |-> mem_model.cycle_count - cyc_base == exp_cycles)
    else begin
      errors = errors + 1;
      $display("ERR %0t: %0d bus cycles, expected %0d", $time,
               mem_model.cycle_count - cyc_base, exp_cycles);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o))
    else begin
      errors = errors + 1;
      $display("Response dropped or changed while the core was stalling it");
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |-> outstanding_r)
    else begin
      errors = errors + 1;
      $display("Response offered with no command outstanding");
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_r |-> !cmd_ready_o)
    else begin
      errors = errors + 1;
      $display("DUT ready for a new command while one is still in flight");
    end

  task automatic step();
    @(posedge clk_i);
    #drive_delay_lp;
  endtask

  function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic [2:0] wrv);
    return {ppn, 9'b0, wrv};
  endfunction

  function automatic logic draw_ready();
    return !stall_mode || ($unsigned($random(seed)) % 4 == 0);
  endfunction

  // Two-level walk straight over the backdoor memory
  task automatic walk(input logic [19:0] vpn, input logic store, output logic fault,
                      output tlb_entry_s ent, output int reads);
    pte_s pte;
    pte   = pte_s'(mem_model.read_word({xlate_i.base_ppn, vpn[19:10], 2'b00}));
    reads = 1;
    if (pte.v && !pte.r && !pte.w) begin
      pte     = pte_s'(mem_model.read_word({pte.ppn, vpn[9:0], 2'b00}));
      reads   = 2;
      ent.ppn = pte.ppn;
    end else begin
      ent.ppn = {pte.ppn[19:10], vpn[9:0]};
    end
    ent.r = pte.r;
    ent.w = pte.w;
    fault = !pte.v || !(pte.r || pte.w) || (store ? !pte.w : !pte.r);
  endtask

  task automatic predict(input mem_op_e op, input logic [31:0] vaddr,
                         output logic [31:0] paddr, output logic fault,
                         output logic miss, output int bus_cycles);
    logic        hit;
    logic        store;
    tlb_entry_s  ent;
    store      = (op == e_store);
    hit        = 1'b0;
    ent        = '0;
    paddr      = vaddr;
    fault      = 1'b0;
    miss       = 1'b0;
    bus_cycles = 1;
    if (xlate_i.en) begin
      for (int i = 0; i < tlb_els_lp; i++) begin
        if (ref_valid[i] && ref_tag[i] == vaddr[31:12]) begin
          hit = 1'b1;
          ent = ref_entry[i];
        end
      end
      if (hit) begin
        fault      = store ? !ent.w : !ent.r;
        bus_cycles = fault ? 0 : 1;
      end else begin
        miss = 1'b1;
        walk(vaddr[31:12], store, fault, ent, bus_cycles);
        if (!fault) begin
          ref_valid[ref_ptr] = 1'b1;
          ref_tag[ref_ptr]   = vaddr[31:12];
          ref_entry[ref_ptr] = ent;
          ref_ptr            = (ref_ptr + 1) % tlb_els_lp;
          bus_cycles         = bus_cycles + 1;
        end
      end
      paddr = {ent.ppn, vaddr[11:0]};
    end
  endtask

  task automatic run_cmd(input mem_op_e op, input logic [31:0] vaddr,
                         input logic [31:0] wdata);
    logic [31:0] paddr;
    logic        fault;
    logic        miss;
    int          bus_cycles;
    predict(op, vaddr, paddr, fault, miss, bus_cycles);
    exp_resp.rdata      = (op == e_load && !fault) ? mem_model.read_word(paddr) : '0;
    exp_resp.page_fault = fault;
    exp_resp.miss       = miss;
    exp_cycles          = bus_cycles;
    cyc_base            = mem_model.cycle_count;
    cmd_i.op            = op;
    cmd_i.vaddr         = vaddr;
    cmd_i.wdata         = wdata;
    cmd_v_i             = 1'b1;
    while (!cmd_ready_o) begin
      step();
    end
    step();
    cmd_v_i      = 1'b0;
    cmd_count    = cmd_count + 1;
    resp_ready_i = draw_ready();
    while (!(resp_v_o && resp_ready_i)) begin
      step();
      resp_ready_i = draw_ready();
    end
    step();
    resp_ready_i = 1'b1;
    if (op == e_store && !fault) begin
      assert (mem_model.read_word(paddr) == wdata)
        else begin
          errors = errors + 1;
          $display("ERR %0t: store to %h left %h in memory", $time, paddr,
                   mem_model.read_word(paddr));
        end
    end
  endtask

  task automatic fence();
    tlb_fence_i = 1'b1;
    step();
    tlb_fence_i = 1'b0;
    for (int i = 0; i < tlb_els_lp; i++) begin
      ref_valid[i] = 1'b0;
    end
  endtask

  task automatic build_tables();
    // Root 1 points at the level-two table, root 3 is a read-only superpage
    mem_model.write_word({root_ppn_lp, 10'd1, 2'b00}, make_pte(l2_ppn_lp, 3'b001));
    mem_model.write_word({root_ppn_lp, 10'd2, 2'b00}, 32'h0);
    mem_model.write_word({root_ppn_lp, 10'd3, 2'b00}, make_pte(20'd0, 3'b011));
    mem_model.write_word({l2_ppn_lp, 10'd0, 2'b00}, make_pte(20'd8, 3'b111));
    mem_model.write_word({l2_ppn_lp, 10'd1, 2'b00}, make_pte(20'd9, 3'b011));
    mem_model.write_word({l2_ppn_lp, 10'd2, 2'b00}, 32'h0);
    mem_model.write_word({l2_ppn_lp, 10'd3, 2'b00}, make_pte(20'd10, 3'b111));
    // Pointer found at level two
    mem_model.write_word({l2_ppn_lp, 10'd4, 2'b00}, make_pte(20'd12, 3'b001));
  endtask

  initial begin
    logic [31:0] ro_word;
    logic [31:0] vaddr;
    logic [31:0] page;
    seed         = 32'h4fd;
    reset_i      = 1'b1;
    cmd_i        = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b1;
    xlate_i      = '0;
    tlb_fence_i  = 1'b0;
    stall_mode   = 1'b0;
    exp_resp     = '0;
    exp_cycles   = 0;
    cyc_base     = 0;
    ref_ptr      = 0;
    for (int i = 0; i < tlb_els_lp; i++) begin
      ref_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk_i);
    #drive_delay_lp;
    reset_i = 1'b0;
    build_tables();

    run_cmd(e_store, 32'h0003_0000, $random(seed));
    run_cmd(e_load,  32'h0003_0000, 32'h0);
    run_cmd(e_store, 32'h0003_0104, $random(seed));
    run_cmd(e_load,  32'h0003_0104, 32'h0);
    run_cmd(e_load,  32'h0003_0200, 32'h0);

    xlate_i.en       = 1'b1;
    xlate_i.base_ppn = root_ppn_lp;
    run_cmd(e_load,  32'h0040_0010, 32'h0);
    run_cmd(e_store, 32'h0040_0010, $random(seed));
    run_cmd(e_load,  32'h0040_0010, 32'h0);
    run_cmd(e_load,  32'h0040_0ffc, 32'h0);
    run_cmd(e_load,  32'h00c0_5010, 32'h0);

    // Invalid leaf, invalid root, pointer at level two
    run_cmd(e_load, 32'h0040_2000, 32'h0);
    run_cmd(e_load, 32'h0080_0000, 32'h0);
    run_cmd(e_load, 32'h0040_4000, 32'h0);
    ro_word = mem_model.read_word(32'h0000_9008);
    run_cmd(e_store, 32'h0040_1008, $random(seed));
    run_cmd(e_load,  32'h0040_1008, 32'h0);
    run_cmd(e_store, 32'h0040_1008, $random(seed));
    assert (mem_model.read_word(32'h0000_9008) == ro_word)
      else begin
        errors = errors + 1;
        $display("ERR %0t: read-only word changed to %h", $time,
                 mem_model.read_word(32'h0000_9008));
      end

    // Remap a cached page, stale until the fence
    run_cmd(e_load, 32'h0040_3020, 32'h0);
    run_cmd(e_load, 32'h0040_3020, 32'h0);
    mem_model.write_word({l2_ppn_lp, 10'd3, 2'b00}, make_pte(20'd11, 3'b111));
    run_cmd(e_load, 32'h0040_3024, 32'h0);
    fence();
    run_cmd(e_load, 32'h0040_3020, 32'h0);

    stall_mode = 1'b1;
    for (int n = 0; n < 12; n++) begin
      page  = $unsigned($random(seed)) % 4;
      vaddr = 32'h0040_0000 | (page << 12) | (32'($random(seed)) & 32'h0000_0ffc);
      run_cmd((($random(seed) & 1) != 0) ? e_store : e_load, vaddr, $random(seed));
    end
    stall_mode = 1'b0;

    assert (resp_count == cmd_count)
      else begin
        errors = errors + 1;
        $display("Responses lost or duplicated");
      end
    $display("Summary: %0d commands, %0d responses, %0d errors",
             cmd_count, resp_count, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/wb_mem_model.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_mem_model
  #(parameter int            words_p     = 65536
    , parameter int          max_delay_p = 4
    , parameter logic [31:0] seed_p      = 32'h4fd
    )
  (input  logic          clk_i
   , input  logic        reset_i
   , input  logic        wb_cyc_i
   , input  logic        wb_stb_i
   , input  logic        wb_we_i
   , input  logic [31:0] wb_adr_i
   , input  logic [31:0] wb_dat_i
   , output logic [31:0] wb_dat_o
   , output logic        wb_ack_o
   );

  localparam int idx_width_lp = $clog2(words_p);

  logic [31:0] mem_r [words_p];
  int          seed;
  int          delay_r;
  logic        busy_r;
  // Completed Wishbone cycles since reset
  int          cycle_count;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    return mem_r[addr[idx_width_lp+1:2]];
  endfunction

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    mem_r[addr[idx_width_lp+1:2]] = data;
  endtask

  // Every word starts as its own byte address with a marker
  initial begin
    seed = seed_p;
    for (int i = 0; i < words_p; i++) begin
      mem_r[i] = (32'(i) << 2) ^ 32'ha5a5_0000;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o    <= 1'b0;
      wb_dat_o    <= '0;
      busy_r      <= 1'b0;
      delay_r     <= 0;
      cycle_count <= 0;
    end else begin
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (!busy_r) begin
          busy_r  <= 1'b1;
          delay_r <= $unsigned($random(seed)) % max_delay_p;
        end else if (delay_r == 0) begin
          busy_r      <= 1'b0;
          wb_ack_o    <= 1'b1;
          cycle_count <= cycle_count + 1;
          if (wb_we_i) begin
            mem_r[wb_adr_i[idx_width_lp+1:2]] = wb_dat_i;
          end else begin
            wb_dat_o <= mem_r[wb_adr_i[idx_width_lp+1:2]];
          end
        end else begin
          delay_r <= delay_r - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire
